// ==== Bender.yml ====
package:
  name: mdu

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mdu_pkg.sv
      - rtl/div_bit_counter.sv
      - rtl/mdu_ctrl_fsm.sv
      - rtl/mult_datapath.sv
      - rtl/div_datapath.sv
      - rtl/mdu_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/mdu_props.sv
      - bench/mdu_tb.sv

// ==== bench/mdu_props.sv ====
// Multiply/divide unit handshake and latency checks
// Bound into the top level, watches the controller state

`include "mdu_settings.svh"

module mdu_props import mdu_pkg::*; (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 start_i,
  input md_op_e               op_i,
  input logic [`MDU_XLEN-1:0] op_b_i,
  input logic                 ready_i,
  input logic                 valid_o,
  input logic [`MDU_XLEN-1:0] result_o,
  input md_state_e            state_i
);

  timeunit 1ns;
  timeprecision 1ps;

  logic accept;
  logic mul_op;
  logic div_op;

  // Start taken only while idle
  assign accept = start_i && (state_i == IDLE);
  assign mul_op = op_i inside {MD_OP_MUL, MD_OP_MULH, MD_OP_MULHSU, MD_OP_MULHU};
  assign div_op = op_i inside {MD_OP_DIV, MD_OP_DIVU, MD_OP_REM, MD_OP_REMU};

  // Nothing valid straight out of reset
  reset_valid_low: assert property (@(posedge clk_i) $rose(rst_ni) |-> !valid_o)
    else $error("valid_o high in the first cycle after reset");

  // Back-pressure freezes the output
  stall_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o && !ready_i |=> valid_o && $stable(result_o))
    else $error("valid_o or result_o changed while ready_i was low");

  // Two multiply steps, then FINISH
  mul_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept && mul_op |=> !valid_o ##1 !valid_o ##1 valid_o)
    else $error("multiply result not valid exactly 3 cycles after start");

  // ABS_A, ABS_B, 31 loop steps, LAST and SIGN
  div_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept && div_op && (op_b_i != '0) |=> !valid_o [*35] ##1 valid_o)
    else $error("divide result not valid exactly 36 cycles after start");

endmodule

bind mdu_top mdu_props u_props (
  .clk_i    (clk_i),
  .rst_ni   (rst_ni),
  .start_i  (start_i),
  .op_i     (op_i),
  .op_b_i   (op_b_i),
  .ready_i  (ready_i),
  .valid_o  (valid_o),
  .result_o (result_o),
  .state_i  (state_q)
);

// ==== bench/mdu_tb.sv ====
// Multiply/divide unit testbench
// Reads one test per line from the data file, drives the DUT on falling edges
// Checks each result, the hold under back-pressure and the single transfer

`include "mdu_settings.svh"

module mdu_tb import mdu_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int    CLK_PERIOD   = 40;
  localparam int    RESET_CYCLES = 3;
  // Cycle budget per test before the stall
  localparam int    TEST_CYCLES  = 40;
  localparam string DATA_FILE    = "bench/mdu_testdata.txt";

  logic                 clk_i;
  logic                 rst_ni;
  logic                 start_i;
  md_op_e               op_i;
  logic [`MDU_XLEN-1:0] op_a_i;
  logic [`MDU_XLEN-1:0] op_b_i;
  logic                 ready_i;
  logic                 valid_o;
  logic [`MDU_XLEN-1:0] result_o;

  // Test table, one entry per data line
  string                name_list[$];
  logic [3:0]           op_list[$];
  logic [`MDU_XLEN-1:0] a_list[$];
  logic [`MDU_XLEN-1:0] b_list[$];
  logic [`MDU_XLEN-1:0] exp_list[$];
  int                   stall_list[$];

  int cycles;
  int cycle_limit;
  int passed;
  int failed;

  mdu_top UUT (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (start_i),
    .op_i     (op_i),
    .op_a_i   (op_a_i),
    .op_b_i   (op_b_i),
    .ready_i  (ready_i),
    .valid_o  (valid_o),
    .result_o (result_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // Run limit from the test lengths
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, the DUT never returned a result", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  //////////////////////////////
  // Test data
  //////////////////////////////
  task automatic load_tests();
    int                   fd;
    int                   code;
    int                   stall;
    string                name;
    string                rest;
    logic [3:0]           op;
    logic [`MDU_XLEN-1:0] a;
    logic [`MDU_XLEN-1:0] b;
    logic [`MDU_XLEN-1:0] exp_res;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      $display("cannot open the test data file %s", DATA_FILE);
      failed++;
    end else begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, "%s", name);
        if (code != 1) break;
        // Lines opening with # describe the columns
        if (name.substr(0, 0) == "#") begin
          code = $fgets(rest, fd);
        end else begin
          code = $fscanf(fd, "%h %h %h %h %d", op, a, b, exp_res, stall);
          if (code == 5) begin
            name_list.push_back(name);
            op_list.push_back(op);
            a_list.push_back(a);
            b_list.push_back(b);
            exp_list.push_back(exp_res);
            stall_list.push_back(stall);
          end else begin
            $display("test %s has a malformed data line", name);
            failed++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  //////////////////////////////
  // One operation
  //////////////////////////////
  task automatic run_test(input int idx);
    mdu_word_u            a_w;
    mdu_word_u            b_w;
    logic [`MDU_XLEN-1:0] first_res;
    int                   test_err;
    test_err = 0;
    a_w.raw  = a_list[idx];
    b_w.raw  = b_list[idx];
    @(negedge clk_i);
    op_i    = md_op_e'(op_list[idx]);
    op_a_i  = a_w.raw;
    op_b_i  = b_w.raw;
    start_i = 1'b1;
    @(negedge clk_i);
    start_i = 1'b0;
    // Handshake wait, the cycle counter bounds it
    while (!valid_o) @(negedge clk_i);
    first_res = result_o;
    assert (first_res === exp_list[idx]) else begin
      $display("mismatch %s expected %h actual %h", name_list[idx], exp_list[idx], first_res);
      test_err++;
    end
    // Consumer stalls, result must hold
    repeat (stall_list[idx]) begin
      @(negedge clk_i);
      assert (valid_o) else begin
        $display("%s: valid_o dropped while ready_i was low", name_list[idx]);
        test_err++;
      end
      assert (result_o === exp_list[idx]) else begin
        $display("mismatch %s expected %h actual %h", name_list[idx], exp_list[idx], result_o);
        test_err++;
      end
    end
    ready_i = 1'b1;
    @(negedge clk_i);
    ready_i = 1'b0;
    // One transfer only
    assert (!valid_o) else begin
      $display("%s: valid_o still high after the result was taken", name_list[idx]);
      test_err++;
    end
    if (test_err == 0) begin
      passed++;
    end else begin
      failed++;
    end
    $display("%s op %0d a %h_%h b %h_%h result %h %s", name_list[idx], op_list[idx],
             a_w.half.top, a_w.half.bot, b_w.half.top, b_w.half.bot, first_res,
             (test_err == 0) ? "ok" : "failed");
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    clk_i   = 1'b0;
    rst_ni  = 1'b0;
    start_i = 1'b0;
    ready_i = 1'b0;
    op_i    = MD_OP_MUL;
    op_a_i  = '0;
    op_b_i  = '0;
    cycles  = 0;
    passed  = 0;
    failed  = 0;
    load_tests();
    cycle_limit = RESET_CYCLES + 2;
    foreach (stall_list[i]) cycle_limit += TEST_CYCLES + stall_list[i];
    if (name_list.size() == 0) begin
      $display("no tests found in %s", DATA_FILE);
      failed++;
    end
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    foreach (name_list[i]) run_test(i);
    $display("tests %0d passed %0d failed %0d", name_list.size(), passed, failed);
    if (failed == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== bench/mdu_testdata.txt ====
# name op a b expected stall
# op, a, b and expected in hex, stall in cycles of ready_i low after valid_o
mul_neg 0 FFFFFFFE 00000003 FFFFFFFA 0
mulh_neg 1 FFFFFFFE 00000003 FFFFFFFF 0
mulhu_neg 3 FFFFFFFE 00000003 00000002 2
mulh_min 1 80000000 FFFFFFFF 00000000 0
mulhsu_min 2 80000000 FFFFFFFF 80000000 0
mulhu_min 3 80000000 FFFFFFFF 7FFFFFFF 0
mulhsu_pos 2 00000002 80000000 00000001 0
smbb16 8 1234FFFE 56780003 FFFFFFFA 0
smtt16 9 80001111 7FFF2222 C0008000 4
div_neg 4 FFFFFFF9 00000002 FFFFFFFD 0
rem_neg 6 FFFFFFF9 00000002 FFFFFFFF 0
div_mix 4 00000007 FFFFFFFE FFFFFFFD 0
rem_mix 6 00000007 FFFFFFFE 00000001 6
divu 5 FFFFFFF9 00000002 7FFFFFFC 0
remu 7 FFFFFFF9 00000002 00000001 0
div_zero 4 12345678 00000000 FFFFFFFF 3
rem_zero 6 12345678 00000000 12345678 0
div_ovf 4 80000000 FFFFFFFF 80000000 0
rem_ovf 6 80000000 FFFFFFFF 00000000 5

// ==== flist.f ====
+incdir+rtl
rtl/mdu_pkg.sv
rtl/div_bit_counter.sv
rtl/mdu_ctrl_fsm.sv
rtl/mult_datapath.sv
rtl/div_datapath.sv
rtl/mdu_top.sv
bench/mdu_props.sv
bench/mdu_tb.sv

// ==== rtl/div_bit_counter.sv ====
// Divide loop bit counter
// Points at the dividend bit shifted into the remainder, flags the final step

`include "mdu_settings.svh"

module div_bit_counter import mdu_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  load_i,
  input  logic                  dec_i,
  output logic [`MDU_CNT_W-1:0] count_o,
  output logic                  last_o
);

  logic [`MDU_CNT_W-1:0] count_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (load_i) begin
      // Top quotient bit first
      count_q <= `MDU_CNT_W'(`MDU_DIV_STEPS - 1);
    end else if (dec_i) begin
      count_q <= count_q - `MDU_CNT_W'(1);
    end
  end

  // Last loop step when one bit is left
  assign last_o  = (count_q == `MDU_CNT_W'(1));
  assign count_o = count_q;

endmodule

// ==== rtl/div_datapath.sv ====
// Divide datapath
// Bit-serial restoring divide on absolute values with one shared subtractor
// Fixes result signs at the end and handles a zero divisor

`include "mdu_settings.svh"

module div_datapath import mdu_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  md_op_e                op_i,
  input  md_state_e             state_i,
  input  logic [`MDU_XLEN-1:0]  op_a_i,
  input  logic [`MDU_XLEN-1:0]  op_b_i,
  input  logic [`MDU_CNT_W-1:0] bit_idx_i,
  output logic                  b_zero_o,
  output logic [`MDU_XLEN-1:0]  result_o
);

  logic [`MDU_XLEN-1:0]  num_q;
  logic [`MDU_XLEN-1:0]  den_q;
  logic [`MDU_XLEN-1:0]  quo_q;
  // One extra bit for the shifted remainder
  logic [`MDU_XLEN:0]    rem_q;
  logic                  neg_quo_q, neg_rem_q;
  logic                  signed_op, rem_op;
  logic                  sign_a, sign_b;
  logic [`MDU_XLEN:0]    sub_a, sub_b;
  logic [`MDU_XLEN+1:0]  sub_res;
  logic                  ge;
  logic [`MDU_XLEN:0]    next_rem;
  logic [`MDU_XLEN-1:0]  quo_bit;
  logic [`MDU_CNT_W-1:0] idx_m1;

  // Operation decode
  assign signed_op = (op_i == MD_OP_DIV) || (op_i == MD_OP_REM);
  assign rem_op    = (op_i == MD_OP_REM) || (op_i == MD_OP_REMU);

  // Raw operand signs, valid before the ABS steps overwrite them
  assign sign_a = signed_op & num_q[`MDU_XLEN-1];
  assign sign_b = signed_op & den_q[`MDU_XLEN-1];

  // Live divisor check for the start decision
  assign b_zero_o = (op_b_i == '0);

  //////////////////////////////
  // Shared subtractor
  //////////////////////////////
  always_comb begin
    // Negation by default
    sub_a = '0;
    sub_b = {1'b0, num_q};
    unique case (state_i)
      ABS_B: sub_b = {1'b0, den_q};
      // Trial subtraction of the divisor
      COMP, LAST: begin
        sub_a = rem_q;
        sub_b = {1'b0, den_q};
      end
      // Negate whichever result the op returns
      SIGN: sub_b = rem_op ? rem_q : {1'b0, quo_q};
      default: sub_b = {1'b0, num_q};
    endcase
  end

  assign sub_res = {1'b0, sub_a} - {1'b0, sub_b};

  // No borrow means remainder >= divisor
  assign ge       = ~sub_res[`MDU_XLEN+1];
  assign next_rem = ge ? sub_res[`MDU_XLEN:0] : rem_q;
  assign quo_bit  = ge ? (`MDU_XLEN'(1) << bit_idx_i) : '0;

  // Next dividend bit to shift in
  assign idx_m1 = bit_idx_i - `MDU_CNT_W'(1);

  //////////////////////////////
  // Payload registers
  //////////////////////////////
  always_ff @(posedge clk_i) begin
    unique case (state_i)
      IDLE: begin
        num_q <= op_a_i;
        den_q <= op_b_i;
        // Zero divisor results, kept if the loop is skipped
        rem_q <= {1'b0, op_a_i};
        quo_q <= '1;
      end
      ABS_A: begin
        num_q <= sign_a ? sub_res[`MDU_XLEN-1:0] : num_q;
        quo_q <= '0;
      end
      ABS_B: begin
        den_q <= sign_b ? sub_res[`MDU_XLEN-1:0] : den_q;
        // Top dividend bit starts the remainder
        rem_q <= {{`MDU_XLEN{1'b0}}, num_q[`MDU_XLEN-1]};
      end
      COMP: begin
        rem_q <= {next_rem[`MDU_XLEN-1:0], num_q[idx_m1]};
        quo_q <= quo_q | quo_bit;
      end
      // Bit 0, no further shift
      LAST: begin
        rem_q <= next_rem;
        quo_q <= quo_q | quo_bit;
      end
      // Only reached with a non-zero divisor
      SIGN: begin
        if (rem_op && neg_rem_q) begin
          rem_q <= {1'b0, sub_res[`MDU_XLEN-1:0]};
        end
        if (!rem_op && neg_quo_q) begin
          quo_q <= sub_res[`MDU_XLEN-1:0];
        end
      end
      // FINISH and the multiply states hold
      default: begin
        rem_q <= rem_q;
      end
    endcase
  end

  //////////////////////////////
  // Control flags
  //////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      neg_quo_q <= 1'b0;
      neg_rem_q <= 1'b0;
    end else if (state_i == ABS_A) begin
      // Quotient sign from both operands, remainder follows the dividend
      neg_quo_q <= sign_a ^ sign_b;
      neg_rem_q <= sign_a;
    end
  end

  assign result_o = rem_op ? rem_q[`MDU_XLEN-1:0] : quo_q;

endmodule

// ==== rtl/mdu_ctrl_fsm.sv ====
// Multiply/divide sequencer
// Latches the operation at start and walks the multiply, packed or divide phases
// Holds FINISH until the consumer takes the result

module mdu_ctrl_fsm import mdu_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      start_i,
  input  md_op_e    op_i,
  input  logic      ready_i,
  input  logic      b_zero_i,
  input  logic      last_i,
  output md_op_e    op_q_o,
  output md_state_e state_o,
  output logic      cnt_load_o,
  output logic      cnt_dec_o,
  output logic      valid_o
);

  md_state_e state_q, state_d;
  md_op_e    op_q;
  logic      op_is_div;
  logic      op_q_packed;

  // Class of the incoming operation
  assign op_is_div = (op_i == MD_OP_DIV) || (op_i == MD_OP_DIVU) ||
                     (op_i == MD_OP_REM) || (op_i == MD_OP_REMU);

  // Packed ops finish after one multiply step
  assign op_q_packed = (op_q == MD_OP_SMBB16) || (op_q == MD_OP_SMTT16);

  //////////////////////////////
  // Next state
  //////////////////////////////
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (start_i) begin
          if (op_is_div) begin
            // Zero divisor needs no loop
            state_d = b_zero_i ? FINISH : ABS_A;
          end else begin
            state_d = MUL_L;
          end
        end
      end
      MUL_L:  state_d = op_q_packed ? FINISH : MUL_H;
      MUL_H:  state_d = FINISH;
      ABS_A:  state_d = ABS_B;
      ABS_B:  state_d = COMP;
      // Leave the loop on the final counter step
      COMP:   state_d = last_i ? LAST : COMP;
      LAST:   state_d = SIGN;
      SIGN:   state_d = FINISH;
      // Back-pressure keeps the result here
      FINISH: state_d = ready_i ? IDLE : FINISH;
      default: state_d = IDLE;
    endcase
  end

  //////////////////////////////
  // State and operation regs
  //////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      op_q    <= MD_OP_MUL;
    end else begin
      state_q <= state_d;
      // Operation sampled only on an accepted start
      if ((state_q == IDLE) && start_i) begin
        op_q <= op_i;
      end
    end
  end

  // Counter control
  assign cnt_load_o = (state_q == ABS_B);
  assign cnt_dec_o  = (state_q == COMP);

  assign valid_o = (state_q == FINISH);
  assign op_q_o  = op_q;
  assign state_o = state_q;

endmodule

// ==== rtl/mdu_pkg.sv ====
// Multiply/divide unit types
// Operation codes, controller states and the operand word view

`include "mdu_settings.svh"

package mdu_pkg;

  // Operation codes, also used by the test data file
  typedef enum logic [3:0] {
    MD_OP_MUL    = 4'd0,
    MD_OP_MULH   = 4'd1,
    MD_OP_MULHSU = 4'd2,
    MD_OP_MULHU  = 4'd3,
    MD_OP_DIV    = 4'd4,
    MD_OP_DIVU   = 4'd5,
    MD_OP_REM    = 4'd6,
    MD_OP_REMU   = 4'd7,
    MD_OP_SMBB16 = 4'd8,
    MD_OP_SMTT16 = 4'd9
  } md_op_e;

  // Controller states
  typedef enum logic [3:0] {
    IDLE   = 4'd0,
    MUL_L  = 4'd1,
    MUL_H  = 4'd2,
    ABS_A  = 4'd3,
    ABS_B  = 4'd4,
    COMP   = 4'd5,
    LAST   = 4'd6,
    SIGN   = 4'd7,
    FINISH = 4'd8
  } md_state_e;

  // Top and bottom half of an operand
  typedef struct packed {
    logic [`MDU_HALF-1:0] top;
    logic [`MDU_HALF-1:0] bot;
  } mdu_half_t;

  // One operand word, read raw or as two halves
  typedef union packed {
    logic [`MDU_XLEN-1:0] raw;
    mdu_half_t            half;
  } mdu_word_u;

endpackage

// ==== rtl/mdu_settings.svh ====
// Multiply/divide unit widths and step counts
// Shared by the package, the datapaths and the top level

`ifndef MDU_SETTINGS_SVH
`define MDU_SETTINGS_SVH

// Data word width as fixed by the ISA
`define MDU_XLEN 32

// Half word width for the packed 16-bit operations
`define MDU_HALF 16

// One quotient bit per divide step
`define MDU_DIV_STEPS 32

// Bit counter width, enough to index 32 dividend bits
`define MDU_CNT_W 5

`endif

// ==== rtl/mdu_top.sv ====
// Multiply/divide unit top level
// Sequencer, divide bit counter and the two datapaths with the result select

`include "mdu_settings.svh"

module mdu_top import mdu_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 start_i,
  input  md_op_e               op_i,
  input  logic [`MDU_XLEN-1:0] op_a_i,
  input  logic [`MDU_XLEN-1:0] op_b_i,
  input  logic                 ready_i,
  output logic                 valid_o,
  output logic [`MDU_XLEN-1:0] result_o
);

  md_op_e                op_q;
  md_state_e             state_q;
  logic                  cnt_load, cnt_dec;
  logic                  b_zero;
  logic                  last;
  logic [`MDU_CNT_W-1:0] bit_idx;
  logic [`MDU_XLEN-1:0]  mul_res, div_res;
  logic                  div_sel;

  // Sequencer
  mdu_ctrl_fsm u_ctrl (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start_i    (start_i),
    .op_i       (op_i),
    .ready_i    (ready_i),
    .b_zero_i   (b_zero),
    .last_i     (last),
    .op_q_o     (op_q),
    .state_o    (state_q),
    .cnt_load_o (cnt_load),
    .cnt_dec_o  (cnt_dec),
    .valid_o    (valid_o)
  );

  // Divide loop index
  div_bit_counter u_cnt (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .load_i  (cnt_load),
    .dec_i   (cnt_dec),
    .count_o (bit_idx),
    .last_o  (last)
  );

  mult_datapath u_mult (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .op_i     (op_q),
    .state_i  (state_q),
    .op_a_i   (op_a_i),
    .op_b_i   (op_b_i),
    .result_o (mul_res)
  );

  div_datapath u_div (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .op_i      (op_q),
    .state_i   (state_q),
    .op_a_i    (op_a_i),
    .op_b_i    (op_b_i),
    .bit_idx_i (bit_idx),
    .b_zero_o  (b_zero),
    .result_o  (div_res)
  );

  // Result source from the latched operation class
  assign div_sel = (op_q == MD_OP_DIV) || (op_q == MD_OP_DIVU) ||
                   (op_q == MD_OP_REM) || (op_q == MD_OP_REMU);

  assign result_o = div_sel ? div_res : mul_res;

endmodule

// ==== rtl/mult_datapath.sv ====
// Multiply datapath
// Three 17-bit signed partial multipliers and a 34-bit intermediate register
// Covers the 32x32 multiplies in two steps and the packed 16x16 ops in one

`include "mdu_settings.svh"

module mult_datapath import mdu_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  md_op_e               op_i,
  input  md_state_e            state_i,
  input  mdu_word_u            op_a_i,
  input  mdu_word_u            op_b_i,
  output logic [`MDU_XLEN-1:0] result_o
);

  mdu_word_u              a_q, b_q;
  logic                   sign_a, sign_b;
  logic                   is_packed;
  logic [`MDU_HALF-1:0]   a1, b1, a3;
  logic                   s1a, s1b, s3a;
  logic signed [33:0]     m1, m2, m3;
  logic signed [33:0]     cross_sum;
  logic signed [33:0]     high_sum;
  logic signed [33:0]     imd_q;

  // Operand signedness per operation
  assign sign_a    = (op_i == MD_OP_MULH) || (op_i == MD_OP_MULHSU);
  assign sign_b    = (op_i == MD_OP_MULH);
  assign is_packed = (op_i == MD_OP_SMBB16) || (op_i == MD_OP_SMTT16);

  //////////////////////////////
  // Operand and sign select
  //////////////////////////////
  always_comb begin
    // Multiplier 1 takes bottom halves, or top halves for SMTT16
    a1 = a_q.half.bot;
    b1 = b_q.half.bot;
    if (op_i == MD_OP_SMTT16) begin
      a1 = a_q.half.top;
      b1 = b_q.half.top;
    end
    // Packed halves are always signed
    s1a = is_packed & a1[`MDU_HALF-1];
    s1b = is_packed & b1[`MDU_HALF-1];
    // Multiplier 3 does bottom x top first, then top x top
    a3  = (state_i == MUL_H) ? a_q.half.top : a_q.half.bot;
    s3a = (state_i == MUL_H) & sign_a & a_q.half.top[`MDU_HALF-1];
  end

  // Partial products
  assign m1 = $signed({s1a, a1}) * $signed({s1b, b1});
  // Top of A times bottom of B
  assign m2 = $signed({sign_a & a_q.half.top[`MDU_HALF-1], a_q.half.top}) *
              $signed({1'b0, b_q.half.bot});
  assign m3 = $signed({s3a, a3}) *
              $signed({sign_b & b_q.half.top[`MDU_HALF-1], b_q.half.top});

  // Bits 47:16 of the product plus carries into the top
  assign cross_sum = $signed({18'b0, m1[31:16]}) + m2 + m3;

  // High word from the shifted cross sum and top x top
  assign high_sum = (imd_q >>> `MDU_HALF) + m3;

  // Operands captured while idle, the start edge keeps the last sample
  always_ff @(posedge clk_i) begin
    if (state_i == IDLE) begin
      a_q <= op_a_i;
      b_q <= op_b_i;
    end
  end

  //////////////////////////////
  // Intermediate register
  //////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      imd_q <= '0;
    end else if (state_i == MUL_L) begin
      // Packed product is final after one step
      imd_q <= is_packed ? m1 : cross_sum;
    end else if (state_i == MUL_H) begin
      if (op_i == MD_OP_MUL) begin
        // Low word joins the cross sum with the bottom x bottom low half
        imd_q <= {2'b00, imd_q[`MDU_HALF-1:0], m1[`MDU_HALF-1:0]};
      end else begin
        imd_q <= high_sum;
      end
    end
  end

  assign result_o = imd_q[`MDU_XLEN-1:0];

endmodule
